//--- finv.f
common/finv_pkg.sv
newton/finv_seed_rom.sv
newton/finv_newton_step.sv
verilog/finv_round_pack.sv
verilog/finv.sv
verification/finv_properties.sv
verification/finv_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := finv_tb
FILELIST   := finv.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "simulation ended without a pass line, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/finv_tb.sv
// drives normal floats only (exponent 1 to 254); expects results exactly two edges after each strobe
`timescale 1ns/1ps

module finv_tb;
    import finv_pkg::*;

    // operand with its expected result, one entry per strobe
    typedef struct packed {
        fp32_t op;
        fp32_t res;
    } expect_t;

    localparam int RAND_COUNT  = 300;
    localparam int DRAIN_LIMIT = 50;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    fp32_t       s;
    logic        out_valid;
    fp32_t       d;

    expect_t     exp_q[$];
    logic [31:0] lcg_state;

    finv u_finv (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .s         (s),
        .out_valid (out_valid),
        .d         (d)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] cur);
        return cur * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] random_word();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    // upper lcg bits, low ones cycle too fast
    function automatic fp32_t random_operand();
        logic [31:0] r1;
        logic [31:0] r2;
        fp32_t       op;
        r1 = random_word();
        r2 = random_word();
        op.sign = r1[31];
        op.exp  = exp_t'(32'd1 + (r1[30:16] % 32'd254));
        op.mant = r2[31:9];
        return op;
    endfunction

    // seed table, two newton steps, exponent and rounded mantissa
    function automatic fp32_t finv_model(input fp32_t op);
        logic [63:0] t;
        logic [63:0] x;
        logic [63:0] c;
        logic [63:0] corr;
        int          q;
        logic        rnd;
        fp32_t       res;
        q = 131072 / (256 + int'(op.mant[22:15])) - 256;
        if (q > 255) begin
            q = 255;
        end
        t = {40'd0, 1'b1, op.mant} << 8;
        x = {32'd0, 1'b1, q[7:0], 23'd0};
        for (int k = 0; k < 2; k++) begin
            c    = (t * x) >> 31;
            corr = (c * x) >> 32;
            x    = (x << 1) - corr;
        end
        res.sign = op.sign;
        if (op.exp == 8'd254) begin
            res.exp = 8'd0;
        end else if (op.mant == 23'd0) begin
            res.exp = 8'd254 - op.exp;
        end else begin
            res.exp = 8'd253 - op.exp;
        end
        // guard x[7], round x[6], sticky x[5:0], ulp x[8]
        rnd = (x[7] && x[6]) || (x[7] && !x[6] && ((|x[5:0]) || x[8]));
        if (op.exp == 8'd253) begin
            res.mant = x[31:9];
        end else if (op.exp == 8'd254) begin
            res.mant = x[32:10];
        end else if (op.mant == 23'd0) begin
            res.mant = 23'd0;
        end else begin
            res.mant = x[30:8] + {22'd0, rnd};
        end
        return res;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            abort_run($sformatf("Mismatch at time %0t: %s, got %h, expected %h",
                                $time, what, got, want));
        end
    endtask

    task automatic drive_operand(input fp32_t op);
        expect_t item;
        item.op  = op;
        item.res = finv_model(op);
        @(posedge clk);
        in_valid <= 1'b1;
        s        <= op;
        exp_q.push_back(item);
    endtask

    // operand bus keeps toggling while idle
    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            in_valid <= 1'b0;
            s        <= random_operand();
        end
    endtask

    task automatic reset_midstream();
        @(posedge clk);
        arst_n   <= 1'b0;
        in_valid <= 1'b0;
        exp_q.delete();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_LIMIT) begin
                abort_run("timeout: results still pending after the last operand");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    // outputs sampled mid-cycle, strobe history two deep
    initial begin : compare
        expect_t item;
        logic    v1;
        logic    v2;
        v1 = 1'b0;
        v2 = 1'b0;
        forever begin
            @(negedge clk);
            if (!arst_n) begin
                check_value(32'(out_valid), 32'd0, "out_valid during reset");
                check_value(d, 32'd0, "d during reset");
                v1 = 1'b0;
                v2 = 1'b0;
            end else begin
                check_value(32'(out_valid), 32'(v2), "out_valid two cycles after in_valid");
                v2 = v1;
                v1 = in_valid;
                if (out_valid) begin
                    if (exp_q.size() == 0) begin
                        abort_run("out_valid was high with no result pending");
                    end
                    item = exp_q.pop_front();
                    check_value(d, item.res, "reciprocal result");
                    // exact reciprocal for powers of two
                    if (item.op.mant == 23'd0 && item.op.exp <= 8'd253) begin
                        check_value(d, {item.op.sign, 8'd254 - item.op.exp, 23'd0},
                                    "power of two reciprocal");
                    end
                end
            end
        end
    end

    initial begin : stimulus
        fp32_t op;
        lcg_state = 32'd19146;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        s         = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // powers of two, sign alternating
        for (int e = 1; e <= 253; e++) begin
            op.sign = e[0];
            op.exp  = exp_t'(e);
            op.mant = '0;
            drive_operand(op);
        end
        drive_idle(3);

        for (int n = 0; n < RAND_COUNT; n++) begin
            drive_operand(random_operand());
        end
        drive_idle(2);

        // the two special mantissa windows
        op.sign = 1'b0;
        op.exp  = EXP_TOP;
        op.mant = '0;
        drive_operand(op);
        for (int n = 0; n < 16; n++) begin
            op     = random_operand();
            op.exp = n[0] ? EXP_TOP : EXP_NEXT;
            drive_operand(op);
        end
        drive_idle(2);

        for (int n = 0; n < 40; n++) begin
            drive_operand(random_operand());
            drive_idle(int'(random_word() % 32'd4));
        end

        for (int n = 0; n < 10; n++) begin
            drive_operand(random_operand());
        end
        reset_midstream();
        for (int n = 0; n < 20; n++) begin
            drive_operand(random_operand());
        end
        drive_idle(1);
        wait_drain();
        drive_idle(4);

        if (exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run("results left in the queue at the end of the run");
        end
    end

endmodule

//--- verification/finv_properties.sv
// valid pipeline checks for finv; assumes reset is held for at least two clock edges
`timescale 1ns/1ps

module finv_properties (
    input logic            clk,
    input logic            arst_n,
    input logic            in_valid,
    input logic            out_valid,
    input finv_pkg::fp32_t d
);

    // strobe comes out two edges after it went in
    property valid_latency_p;
        @(posedge clk) disable iff (!arst_n)
            out_valid == $past(in_valid, 2);
    endproperty

    property result_known_p;
        @(posedge clk) disable iff (!arst_n)
            out_valid |-> !$isunknown(d);
    endproperty

    // async clear, so checked away from the rising edge
    property reset_clears_p;
        @(negedge clk) !arst_n |-> !out_valid;
    endproperty

    valid_latency_a: assert property (valid_latency_p)
        else $error("out_valid does not follow in_valid by two cycles");

    result_known_a: assert property (result_known_p)
        else $error("result has unknown bits while out_valid is high");

    reset_clears_a: assert property (reset_clears_p)
        else $error("out_valid is high while reset is asserted");

endmodule

bind finv finv_properties u_finv_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .d         (d)
);

//--- verilog/finv.sv
// float reciprocal, 2-cycle latency, one operand per cycle, no back-pressure; normal inputs only
`timescale 1ns/1ps

module finv (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  finv_pkg::fp32_t s,
    output logic            out_valid,
    output finv_pkg::fp32_t d
);
    import finv_pkg::*;

    seed_idx_t   seed_idx;
    seed_t       seed;
    fix_t        target_s;
    fix_t        x0;
    fix_t        x1;

    finv_stage_t stage_d;
    finv_stage_t stage_q;
    logic        stage_valid_q;

    fix_t        target_q;
    fix_t        x2;
    fp32_t       res;

    // significand with hidden one, placed at TARGET_LSB
    function automatic fix_t to_target(fp32_t f);
        sig_t sig;
        sig = {1'b1, f.mant};
        return fix_t'(sig) << TARGET_LSB;
    endfunction

    // stage one: seed lookup and first refinement
    assign seed_idx = s.mant[$bits(mant_t)-1 -: $bits(seed_idx_t)];
    assign target_s = to_target(s);

    finv_seed_rom u_seed_rom (
        .idx  (seed_idx),
        .seed (seed)
    );

    // one at bit 31, seed right below, low bits zero
    assign x0 = (fix_t'(1'b1) << (SEED_LSB + $bits(seed_t))) | (fix_t'(seed) << SEED_LSB);

    finv_newton_step u_step1 (
        .target (target_s),
        .x_in   (x0),
        .x_out  (x1)
    );

    assign stage_d.op = s;
    assign stage_d.x1 = x1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_q <= '0;
        end else if (in_valid) begin
            stage_q <= stage_d;
        end
    end

    // stage two: second refinement, round and pack
    assign target_q = to_target(stage_q.op);

    finv_newton_step u_step2 (
        .target (target_q),
        .x_in   (stage_q.x1),
        .x_out  (x2)
    );

    finv_round_pack u_round_pack (
        .op (stage_q.op),
        .x2 (x2),
        .d  (res)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            d <= '0;
        end else if (stage_valid_q) begin
            d <= res;
        end
    end

    // valid strobe follows the data two edges deep
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid_q <= 1'b0;
            out_valid     <= 1'b0;
        end else begin
            stage_valid_q <= in_valid;
            out_valid     <= stage_valid_q;
        end
    end

endmodule

//--- verilog/finv_round_pack.sv
// result exponent, mantissa selection with nearest-even rounding, float packing; no special values
`timescale 1ns/1ps

module finv_round_pack (
    input  finv_pkg::fp32_t op,
    input  finv_pkg::fix_t  x2,
    output finv_pkg::fp32_t d
);
    import finv_pkg::*;

    localparam int MW = $bits(mant_t);

    logic  mant_zero;
    exp_t  exp_res;
    mant_t mant_res;

    // rounding bits around the ulp of x2
    logic  ulp_bit;
    logic  guard_bit;
    logic  round_bit;
    logic  sticky_bit;
    logic  rnd_flag;

    mant_t win_top;
    mant_t win_next;
    mant_t win_norm;

    assign mant_zero = (op.mant == '0);

    // 1/2^(e-127) gives 254 - e for powers of two, one less otherwise
    always_comb begin
        if (op.exp == EXP_TOP) begin
            exp_res = '0;
        end else if (mant_zero) begin
            exp_res = EXP_TOP - op.exp;
        end else begin
            exp_res = EXP_NEXT - op.exp;
        end
    end

    assign ulp_bit    = x2[RND_ULP];
    assign guard_bit  = x2[RND_ULP-1];
    assign round_bit  = x2[RND_ULP-2];
    assign sticky_bit = |x2[RND_ULP-3:0];

    // ties go to even
    assign rnd_flag = (guard_bit && round_bit) ||
                      (guard_bit && !round_bit && (sticky_bit || ulp_bit));

    // windows shifted up for the two largest exponents
    assign win_next = x2[RND_ULP+MW : RND_ULP+1];
    assign win_top  = x2[RND_ULP+MW+1 : RND_ULP+2];
    assign win_norm = x2[RND_ULP+MW-1 : RND_ULP];

    always_comb begin
        if (op.exp == EXP_NEXT) begin
            mant_res = win_next;
        end else if (op.exp == EXP_TOP) begin
            mant_res = win_top;
        end else if (mant_zero) begin
            mant_res = '0;
        end else begin
            // wraps in 23 bits
            mant_res = win_norm + mant_t'(rnd_flag);
        end
    end

    assign d.sign = op.sign;
    assign d.exp  = exp_res;
    assign d.mant = mant_res;

endmodule

//--- newton/finv_newton_step.sv
// one newton-raphson reciprocal step in 64-bit fixed point; all products wrap at 64 bits
`timescale 1ns/1ps

module finv_newton_step (
    input  finv_pkg::fix_t target,
    input  finv_pkg::fix_t x_in,
    output finv_pkg::fix_t x_out
);
    import finv_pkg::*;

    fix_t prod_tx;
    fix_t c;
    fix_t prod_cx;
    fix_t e;
    fix_t x_dbl;

    // t * x, back to estimate scale
    assign prod_tx = target * x_in;
    assign c       = prod_tx >> MUL_SHIFT;

    // (t * x) * x, the squared correction term
    assign prod_cx = c * x_in;
    assign e       = prod_cx >> SQ_SHIFT;

    // x' = 2x - t*x^2
    assign x_dbl = x_in << 1;
    assign x_out = x_dbl - e;

endmodule

//--- newton/finv_seed_rom.sv
// reciprocal seed table, 256 entries from the top 8 mantissa bits; pure combinational read
`timescale 1ns/1ps

module finv_seed_rom (
    input  finv_pkg::seed_idx_t idx,
    output finv_pkg::seed_t     seed
);
    import finv_pkg::*;

    localparam int DEPTH = 2 ** $bits(seed_idx_t);

    // 2^17 over (256 + i) lands in [256, 512]
    localparam int SEED_NUM  = 131072;
    localparam int SEED_BASE = 256;
    localparam int SEED_MAX  = 2 ** $bits(seed_t) - 1;

    typedef seed_t [DEPTH-1:0] seed_tab_t;

    // seed(i) = floor(2^17 / (256 + i)) - 256, clipped to 8 bits
    function automatic seed_tab_t build_seed_tab();
        seed_tab_t tab;
        int        q;
        tab = '0;
        for (int i = 0; i < DEPTH; i++) begin
            q = SEED_NUM / (SEED_BASE + i) - SEED_BASE;
            // only i = 0 overshoots
            if (q > SEED_MAX) begin
                tab[i] = seed_t'(SEED_MAX);
            end else begin
                tab[i] = seed_t'(q);
            end
        end
        return tab;
    endfunction

    localparam seed_tab_t SEED_TAB = build_seed_tab();

    // plain indexed read, maps to a rom
    assign seed = SEED_TAB[idx];

endmodule

//--- common/finv_pkg.sv
// shared float fields and fixed-point types; normal operands only (exponent 1 to 254)
package finv_pkg;

    // biased exponent
    typedef logic [7:0] exp_t;

    // stored mantissa, hidden one omitted
    typedef logic [22:0] mant_t;

    // significand with hidden one restored
    typedef logic [23:0] sig_t;

    // newton arithmetic word
    typedef logic [63:0] fix_t;

    // seed table entry and its index
    typedef logic [7:0] seed_t;
    typedef logic [7:0] seed_idx_t;

    // ieee-754 single precision layout
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
    } fp32_t;

    // carried from stage one into stage two
    typedef struct packed {
        fp32_t op;
        fix_t  x1;
    } finv_stage_t;

    // right shifts after t*x and c*x in a newton step
    localparam int MUL_SHIFT = 31;
    localparam int SQ_SHIFT  = 32;

    // significand position inside the target word
    localparam int TARGET_LSB = 8;

    // seed position inside the initial estimate, the one sits just above it
    localparam int SEED_LSB = 23;

    // unit in last place of x2, guard/round/sticky below it
    localparam int RND_ULP = 8;

    // exponents with their own mantissa windows
    localparam exp_t EXP_TOP  = 8'd254;
    localparam exp_t EXP_NEXT = 8'd253;

endpackage
